// ==== common/pwm_pkg.sv ====
package pwm_pkg;

    // Counter runs half a period down then half up
    localparam int PWM_PERIOD    = 200;
    localparam int HALF_PERIOD   = PWM_PERIOD / 2;
    localparam int CNT_WIDTH     = $clog2(HALF_PERIOD + 1);
    localparam int MAX_ON_CYCLES = 190;     // Longest on time per period

    localparam int DUTY_WIDTH    = 12;

    // Command FIFO
    localparam int FIFO_DEPTH    = 4;
    localparam int LEVEL_WIDTH   = $clog2(FIFO_DEPTH + 1);

    // Wishbone
    localparam int WB_DATA_WIDTH = 32;
    localparam int WB_ADDR_WIDTH = 3;

    // Word addresses
    localparam logic [WB_ADDR_WIDTH-1:0] REG_DUTY_U = 'd0;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_DUTY_V = 'd1;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_DUTY_W = 'd2;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_COMMIT = 'd3;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_CTRL   = 'd4;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_STATUS = 'd5;

    // One duty command for all three phases
    typedef struct packed {
        logic [DUTY_WIDTH-1:0] u;
        logic [DUTY_WIDTH-1:0] v;
        logic [DUTY_WIDTH-1:0] w;
    } duty_cmd_t;

endpackage

// ==== hdl/wb_duty_regs.sv ====
`timescale 1ns/1ps

module wb_duty_regs (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                cyc,
    input  logic                                stb,
    input  logic                                we,
    input  logic [pwm_pkg::WB_ADDR_WIDTH-1:0]   adr,
    input  logic [pwm_pkg::WB_DATA_WIDTH-1:0]   dat_w,
    output logic [pwm_pkg::WB_DATA_WIDTH-1:0]   dat_r,
    output logic                                ack,
    input  logic                                fault,
    input  logic [pwm_pkg::LEVEL_WIDTH-1:0]     fifo_level,
    output logic                                push_valid,
    input  logic                                push_ready,
    output pwm_pkg::duty_cmd_t                  push_cmd,
    output logic                                enable
);

    typedef logic [pwm_pkg::WB_DATA_WIDTH-1:0] word_t;

    logic                           req;
    logic                           wr;
    logic [pwm_pkg::DUTY_WIDTH-1:0] duty_u;
    logic [pwm_pkg::DUTY_WIDTH-1:0] duty_v;
    logic [pwm_pkg::DUTY_WIDTH-1:0] duty_w;
    logic                           fault_latched;
    logic                           overflow;
    word_t                          read_word;

    assign req = cyc & stb & ~ack;  // New access, not yet acked
    assign wr  = req & we;

    always_comb begin
        case (adr)
            pwm_pkg::REG_DUTY_U: read_word = word_t'(duty_u);
            pwm_pkg::REG_DUTY_V: read_word = word_t'(duty_v);
            pwm_pkg::REG_DUTY_W: read_word = word_t'(duty_w);
            pwm_pkg::REG_CTRL:   read_word = word_t'(enable);
            pwm_pkg::REG_STATUS: read_word = word_t'({fifo_level, overflow, fault_latched});
            default:             read_word = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack           <= 1'b0;
            push_valid    <= 1'b0;
            duty_u        <= '0;
            duty_v        <= '0;
            duty_w        <= '0;
            enable        <= 1'b0;
            fault_latched <= 1'b0;
            overflow      <= 1'b0;
        end else begin
            ack        <= req;
            push_valid <= wr && (adr == pwm_pkg::REG_COMMIT);   // One-cycle push
            if (wr) begin
                case (adr)
                    pwm_pkg::REG_DUTY_U: duty_u <= dat_w[pwm_pkg::DUTY_WIDTH-1:0];
                    pwm_pkg::REG_DUTY_V: duty_v <= dat_w[pwm_pkg::DUTY_WIDTH-1:0];
                    pwm_pkg::REG_DUTY_W: duty_w <= dat_w[pwm_pkg::DUTY_WIDTH-1:0];
                    pwm_pkg::REG_CTRL:   enable <= dat_w[0];
                    default: ;
                endcase
            end
            // New event wins over the clear
            if (fault) begin
                fault_latched <= 1'b1;
            end else if (wr && (adr == pwm_pkg::REG_STATUS) && dat_w[0]) begin
                fault_latched <= 1'b0;
            end
            if (push_valid && !push_ready) begin
                overflow <= 1'b1;   // Command dropped
            end else if (wr && (adr == pwm_pkg::REG_STATUS) && dat_w[1]) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            dat_r <= read_word;
        end
        if (wr && (adr == pwm_pkg::REG_COMMIT)) begin
            push_cmd.u <= duty_u;
            push_cmd.v <= duty_v;
            push_cmd.w <= duty_w;
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack);

endmodule

// ==== hdl/cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo #(
    parameter type payload_t = logic
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  payload_t                        in_data,
    output logic                            out_valid,
    input  logic                            out_ready,
    output payload_t                        out_data,
    output logic [pwm_pkg::LEVEL_WIDTH-1:0] level
);

    typedef logic [$clog2(pwm_pkg::FIFO_DEPTH)-1:0] ptr_t;

    payload_t                        mem [pwm_pkg::FIFO_DEPTH];
    ptr_t                            wr_ptr;
    ptr_t                            rd_ptr;
    logic [pwm_pkg::LEVEL_WIDTH-1:0] count;
    logic                            push;
    logic                            pop;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        if (ptr == ptr_t'(pwm_pkg::FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count < pwm_pkg::FIFO_DEPTH);
    assign out_valid = (count != '0);
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;
    assign out_data  = mem[rd_ptr];    // Head of queue
    assign level     = count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= pwm_pkg::FIFO_DEPTH);

endmodule

// ==== hdl/pwm_period_timer.sv ====
`timescale 1ns/1ps

module pwm_period_timer (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    output logic trigger
);

    logic [$clog2(pwm_pkg::PWM_PERIOD)-1:0] count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count   <= '0;
            trigger <= 1'b0;
        end else begin
            trigger <= enable && (count == '0);   // Start of period
            if (!enable) begin
                count <= '0;
            end else if (count == pwm_pkg::PWM_PERIOD - 1) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// ==== pwm_driver/ds_pwm_driver.sv ====
`timescale 1ns/1ps

module ds_pwm_driver (
    input  logic               clk,
    input  logic               reset,
    input  logic               trigger,
    input  logic               fault,
    input  logic               cmd_valid,
    output logic               cmd_ready,
    input  pwm_pkg::duty_cmd_t cmd,
    output logic [2:0]         driver_pwm,        // {u, v, w}
    output logic [2:0]         driver_reset_n
);

    typedef logic [pwm_pkg::CNT_WIDTH-1:0] cnt_t;
    typedef logic [pwm_pkg::CNT_WIDTH:0]   cmp_t;

    logic       dir;                // 0 down, 1 up
    cnt_t       counter;
    logic       drive;
    logic       staged;
    cmp_t       duty_clip [3];
    cmp_t       stage_cmp [3];
    cmp_t       cmp       [3];
    cmp_t       half_cmp  [3];
    logic [2:0] pwm_ff;
    logic       reset_n_ff;

    function automatic cmp_t clip_duty(input logic [pwm_pkg::DUTY_WIDTH-1:0] duty);
        if (duty < pwm_pkg::MAX_ON_CYCLES) begin
            return cmp_t'(duty);
        end
        return cmp_t'(pwm_pkg::MAX_ON_CYCLES);
    endfunction

    assign cmd_ready = ~staged;

    always_comb begin
        duty_clip[2] = clip_duty(cmd.u);
        duty_clip[1] = clip_duty(cmd.v);
        duty_clip[0] = clip_duty(cmd.w);
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            stage_cmp <= duty_clip;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            staged  <= 1'b0;
            drive   <= 1'b0;
            dir     <= 1'b0;
            counter <= cnt_t'(pwm_pkg::HALF_PERIOD - 1);
            cmp     <= '{default: '0};
        end else if (fault) begin
            staged  <= 1'b0;    // Pending command is lost
            drive   <= 1'b0;
            dir     <= 1'b0;
            counter <= cnt_t'(pwm_pkg::HALF_PERIOD - 1);
        end else begin
            if (trigger && staged) begin
                staged <= 1'b0;
            end else if (cmd_valid && cmd_ready) begin
                staged <= 1'b1;
            end
            if (trigger) begin
                dir     <= 1'b0;
                counter <= cnt_t'(pwm_pkg::HALF_PERIOD - 1);
                if (staged) begin
                    drive <= 1'b1;
                    cmp   <= stage_cmp;
                end
            end else if (!dir) begin
                if (counter != '0) begin
                    counter <= counter - 1'b1;
                end else begin
                    dir <= 1'b1;    // Hold zero one more cycle
                end
            end else if (counter != cnt_t'(pwm_pkg::HALF_PERIOD - 1)) begin
                counter <= counter + 1'b1;
            end
        end
    end

    // Odd duties put the extra cycle on the up slope
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            half_cmp[i] = (cmp[i] + cmp_t'(dir)) >> 1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_ff         <= '0;
            reset_n_ff     <= 1'b0;
            driver_pwm     <= '0;
            driver_reset_n <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                pwm_ff[i] <= drive & ~fault & (cmp_t'(counter) < half_cmp[i]);
            end
            reset_n_ff     <= drive & ~fault;
            driver_pwm     <= pwm_ff;
            driver_reset_n <= {3{reset_n_ff}};
        end
    end

    a_pwm_off_in_reset: assert property (@(posedge clk) disable iff (reset)
        (driver_reset_n == 3'b000) |-> (driver_pwm == 3'b000));

endmodule

// ==== hdl/motor_pwm_top.sv ====
`timescale 1ns/1ps

module motor_pwm_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [pwm_pkg::WB_ADDR_WIDTH-1:0] adr,
    input  logic [pwm_pkg::WB_DATA_WIDTH-1:0] dat_w,
    output logic [pwm_pkg::WB_DATA_WIDTH-1:0] dat_r,
    output logic                              ack,
    input  logic                              fault,
    output logic [2:0]                        driver_pwm,
    output logic [2:0]                        driver_reset_n
);

    logic                            push_valid;
    logic                            push_ready;
    pwm_pkg::duty_cmd_t              push_cmd;
    logic                            cmd_valid;
    logic                            cmd_ready;
    pwm_pkg::duty_cmd_t              cmd;
    logic [pwm_pkg::LEVEL_WIDTH-1:0] fifo_level;
    logic                            enable;
    logic                            trigger;

    wb_duty_regs u_wb_duty_regs (
        .clk        (clk),
        .reset      (reset),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .fault      (fault),
        .fifo_level (fifo_level),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .push_cmd   (push_cmd),
        .enable     (enable)
    );

    cmd_fifo #(
        .payload_t (pwm_pkg::duty_cmd_t)
    ) u_cmd_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (push_valid),
        .in_ready  (push_ready),
        .in_data   (push_cmd),
        .out_valid (cmd_valid),
        .out_ready (cmd_ready),
        .out_data  (cmd),
        .level     (fifo_level)
    );

    pwm_period_timer u_pwm_period_timer (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .trigger (trigger)
    );

    ds_pwm_driver u_ds_pwm_driver (
        .clk            (clk),
        .reset          (reset),
        .trigger        (trigger),
        .fault          (fault),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .cmd            (cmd),
        .driver_pwm     (driver_pwm),
        .driver_reset_n (driver_reset_n)
    );

endmodule

// ==== dv/tb_motor_pwm.sv ====
`timescale 1ns/1ps

module tb_motor_pwm;

    localparam int ACK_TIMEOUT   = 16;
    localparam int FAULT_TIMEOUT = 3;

    logic                              clk;
    logic                              reset;
    logic                              cyc;
    logic                              stb;
    logic                              we;
    logic [pwm_pkg::WB_ADDR_WIDTH-1:0] adr;
    logic [pwm_pkg::WB_DATA_WIDTH-1:0] dat_w;
    logic [pwm_pkg::WB_DATA_WIDTH-1:0] dat_r;
    logic                              ack;
    logic                              fault;
    logic [2:0]                        driver_pwm;
    logic [2:0]                        driver_reset_n;

    int error_count;
    int timeout_count;

    motor_pwm_top u_motor_pwm_top (
        .clk            (clk),
        .reset          (reset),
        .cyc            (cyc),
        .stb            (stb),
        .we             (we),
        .adr            (adr),
        .dat_w          (dat_w),
        .dat_r          (dat_r),
        .ack            (ack),
        .fault          (fault),
        .driver_pwm     (driver_pwm),
        .driver_reset_n (driver_reset_n)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #10;    // Drive and sample point
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s actual=0x%h expected=0x%h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic wb_access(input logic write, input logic [pwm_pkg::WB_ADDR_WIDTH-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int   cycles;
        logic seen;
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = write;
        adr    = addr;
        dat_w  = wdata;
        cycles = 0;
        seen   = 1'b0;
        rdata  = '0;
        while (!seen && cycles < ACK_TIMEOUT) begin
            tick();
            cycles++;
            if (ack) begin
                seen  = 1'b1;
                rdata = dat_r;  // Valid during ack
            end
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        if (!seen) begin
            $display("Timeout: no Wishbone ack for access to address %0d", addr);
            timeout_count++;
        end
    endtask

    task automatic wb_write(input logic [pwm_pkg::WB_ADDR_WIDTH-1:0] addr,
                            input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input logic [pwm_pkg::WB_ADDR_WIDTH-1:0] addr,
                           output logic [31:0] data);
        wb_access(1'b0, addr, '0, data);
    endtask

    task automatic measure_high(output int high_u, output int high_v, output int high_w);
        high_u = 0;
        high_v = 0;
        high_w = 0;
        repeat (pwm_pkg::PWM_PERIOD) begin
            tick();
            high_u += driver_pwm[2];
            high_v += driver_pwm[1];
            high_w += driver_pwm[0];
        end
    endtask

    task automatic apply_fault();
        logic [31:0] rdata;
        int          cycles;
        fault  = 1'b1;
        cycles = 0;
        while ((driver_pwm != 3'b000 || driver_reset_n != 3'b000) && cycles < FAULT_TIMEOUT) begin
            tick();
            cycles++;
        end
        check_value("driver_pwm", driver_pwm, 3'b000);
        check_value("driver_reset_n", driver_reset_n, 3'b000);
        repeat (4) tick();
        wb_read(pwm_pkg::REG_STATUS, rdata);
        check_value("status.fault", rdata[0], 1'b1);
        fault = 1'b0;
        tick();
        wb_write(pwm_pkg::REG_STATUS, 32'h1);   // Write-one-to-clear
        wb_read(pwm_pkg::REG_STATUS, rdata);
        check_value("status.fault", rdata[0], 1'b0);
    endtask

    task automatic run_step(input int u, input int v, input int w, input int with_fault,
                            input int exp_u, input int exp_v, input int exp_w);
        logic [31:0] rdata;
        int          high_u;
        int          high_v;
        int          high_w;
        wb_write(pwm_pkg::REG_DUTY_U, u);
        wb_write(pwm_pkg::REG_DUTY_V, v);
        wb_write(pwm_pkg::REG_DUTY_W, w);
        wb_read(pwm_pkg::REG_DUTY_U, rdata);
        check_value("duty_u", rdata, u);
        wb_read(pwm_pkg::REG_DUTY_V, rdata);
        check_value("duty_v", rdata, v);
        wb_read(pwm_pkg::REG_DUTY_W, rdata);
        check_value("duty_w", rdata, w);
        if (with_fault != 0) begin
            apply_fault();
        end
        wb_write(pwm_pkg::REG_COMMIT, 32'h0);
        repeat (2 * pwm_pkg::PWM_PERIOD) tick();    // New duty fully in effect
        measure_high(high_u, high_v, high_w);
        check_value("high_u", high_u, exp_u);
        check_value("high_v", high_v, exp_v);
        check_value("high_w", high_w, exp_w);
        check_value("driver_reset_n", driver_reset_n, 3'b111);  // Gate drivers released
    endtask

    task automatic overflow_test();
        logic [31:0] rdata;
        wb_write(pwm_pkg::REG_CTRL, 32'h0);
        repeat (6) wb_write(pwm_pkg::REG_COMMIT, 32'h0);
        wb_read(pwm_pkg::REG_STATUS, rdata);
        check_value("status.level", rdata[4:2], pwm_pkg::FIFO_DEPTH);
        check_value("status.overflow", rdata[1], 1'b1);
        wb_write(pwm_pkg::REG_STATUS, 32'h2);
        wb_read(pwm_pkg::REG_STATUS, rdata);
        check_value("status.overflow", rdata[1], 1'b0);
    endtask

    initial begin
        int               fd;
        int               code;
        int               fields;
        int               steps;
        int               u;
        int               v;
        int               w;
        int               fault_flag;
        int               exp_u;
        int               exp_v;
        int               exp_w;
        logic [8*256-1:0] line;
        logic [31:0]      rdata;
        error_count   = 0;
        timeout_count = 0;
        steps         = 0;
        reset         = 1'b1;
        cyc           = 1'b0;
        stb           = 1'b0;
        we            = 1'b0;
        adr           = '0;
        dat_w         = '0;
        fault         = 1'b0;
        repeat (8) begin
            tick();
            check_value("ack", ack, 1'b0);
            check_value("driver_pwm", driver_pwm, 3'b000);
            check_value("driver_reset_n", driver_reset_n, 3'b000);
        end
        reset = 1'b0;
        tick();
        wb_write(pwm_pkg::REG_CTRL, 32'h1);
        wb_read(pwm_pkg::REG_CTRL, rdata);
        check_value("ctrl.enable", rdata, 32'h1);
        fd = $fopen("dv/motor_pwm_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file dv/motor_pwm_testdata.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                code   = $fgets(line, fd);
                fields = $sscanf(line, "%d %d %d %d %d %d %d",
                                 u, v, w, fault_flag, exp_u, exp_v, exp_w);
                if (code > 0 && fields == 7) begin    // Comment lines give no fields
                    run_step(u, v, w, fault_flag, exp_u, exp_v, exp_w);
                    steps++;
                end
            end
            $fclose(fd);
            if (steps == 0) begin
                $display("The test data file held no test steps");
                error_count++;
            end
        end
        overflow_test();
        $display("Summary: %0d steps, %0d errors, %0d timeouts", steps, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== dv/motor_pwm_testdata.txt ====
# Columns: duty_u duty_v duty_w fault exp_high_u exp_high_v exp_high_w
# Decimal values, fault 1 asserts the fault input before the commit
100 50 150 0 100 50 150
1 2 3 0 1 2 3
189 190 191 0 189 190 190
4095 0 300 0 190 0 190
0 0 0 0 0 0 0
99 101 100 0 99 101 100
120 60 30 1 120 60 30
77 199 8 0 77 190 8
200 189 1 0 190 189 1
10 20 40 1 10 20 40
55 155 255 0 55 155 190

// ==== src.f ====
common/pwm_pkg.sv
hdl/wb_duty_regs.sv
hdl/cmd_fifo.sv
hdl/pwm_period_timer.sv
pwm_driver/ds_pwm_driver.sv
hdl/motor_pwm_top.sv
dv/tb_motor_pwm.sv

// ==== Bender.yml ====
package:
  name: motor_pwm

sources:
  - common/pwm_pkg.sv
  - hdl/wb_duty_regs.sv
  - hdl/cmd_fifo.sv
  - hdl/pwm_period_timer.sv
  - pwm_driver/ds_pwm_driver.sv
  - hdl/motor_pwm_top.sv
  - target: simulation
    files:
      - dv/tb_motor_pwm.sv
